/* common/tcdm_settings.svh */
`ifndef TCDM_SETTINGS_SVH
`define TCDM_SETTINGS_SVH

// Bus widths of the TCDM port
`define TCDM_ADDR_WIDTH 32
`define TCDM_DATA_WIDTH 32
`define TCDM_BE_WIDTH 4

// Bank organisation
`define TCDM_NR_BANKS 3
`define TCDM_BANK_DEPTH 256

// Bank 2 stalls its grant for this many cycles
`define TCDM_BANK2_WAIT 2

// Each bank owns one region of this many bytes, starting at the map base
`define TCDM_BANK_REGION 32'h0000_1000
`define TCDM_MAP_BASE 32'h0000_0000

`endif

/* common/tcdm_pkg.sv */
`default_nettype none

`include "tcdm_settings.svh"

package tcdm_pkg;

    // --------------------------------------------------
    // Request channel, driven by the master
    // --------------------------------------------------

    // A high wen marks a read, a low wen a write
    typedef struct packed {
        logic                         req;
        logic [`TCDM_ADDR_WIDTH-1:0]  add;
        logic                         wen;
        logic [`TCDM_DATA_WIDTH-1:0]  wdata;
        logic [`TCDM_BE_WIDTH-1:0]    be;
    } tcdm_req_t;

    // --------------------------------------------------
    // Response channel, driven by the slave
    // --------------------------------------------------

    // The gnt bit belongs to the request phase, the rest comes with r_valid
    // A high r_opc flags a failed access
    typedef struct packed {
        logic                         gnt;
        logic                         r_valid;
        logic [`TCDM_DATA_WIDTH-1:0]  r_rdata;
        logic                         r_opc;
    } tcdm_rsp_t;

    // One entry of the address map
    // The range covers start_addr up to but not including end_addr
    typedef struct packed {
        logic [$clog2(`TCDM_NR_BANKS)-1:0] idx;
        logic [`TCDM_ADDR_WIDTH-1:0]       start_addr;
        logic [`TCDM_ADDR_WIDTH-1:0]       end_addr;
    } addr_map_rule_t;

endpackage

`default_nettype wire

/* src/addr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_settings.svh"

// Matches an address against a list of rules and returns the target index
module addr_decode #(
    parameter int unsigned NR_RULES = `TCDM_NR_BANKS,
    parameter int unsigned NR_IDX   = `TCDM_NR_BANKS,
    localparam int unsigned IDX_WIDTH = (NR_IDX > 1) ? $clog2(NR_IDX) : 1
) (
    input  logic [`TCDM_ADDR_WIDTH-1:0] addr_i,
    input  tcdm_pkg::addr_map_rule_t    addr_map_i [NR_RULES],
    output logic [IDX_WIDTH-1:0]        idx_o,
    output logic                        dec_valid_o
);

    // --------------------------------------------------
    // Rule scan
    // --------------------------------------------------

    // Every rule is checked in order, so a later match overrides an earlier one
    // With no match at all the index stays at zero and the valid flag stays low
    always_comb begin
        idx_o       = '0;
        dec_valid_o = 1'b0;
        for (int unsigned i = 0; i < NR_RULES; i++) begin
            // The end address is exclusive
            if ((addr_i >= addr_map_i[i].start_addr) &&
                (addr_i < addr_map_i[i].end_addr)) begin
                idx_o       = IDX_WIDTH'(addr_map_i[i].idx);
                dec_valid_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tcdm_demux/tcdm_demux.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_settings.svh"

// Routes one TCDM master port to one of several bank ports
module tcdm_demux #(
    parameter int unsigned NR_OUTPUTS = `TCDM_NR_BANKS
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  tcdm_pkg::addr_map_rule_t addr_map_i [NR_OUTPUTS],
    input  tcdm_pkg::tcdm_req_t      master_req_i,
    output tcdm_pkg::tcdm_rsp_t      master_rsp_o,
    output tcdm_pkg::tcdm_req_t      bank_req_o [NR_OUTPUTS],
    input  tcdm_pkg::tcdm_rsp_t      bank_rsp_i [NR_OUTPUTS]
);

    localparam int unsigned SEL_WIDTH = (NR_OUTPUTS > 1) ? $clog2(NR_OUTPUTS) : 1;

    typedef enum logic {
        IDLE,
        PENDING
    } state_e;

    state_e               state_d, state_q;
    logic [SEL_WIDTH-1:0] active_d, active_q;
    logic [SEL_WIDTH-1:0] port_sel;
    // High when the master request is passed on to the decoded bank
    logic                 fwd_req;

    // --------------------------------------------------
    // Address decoding
    // --------------------------------------------------

    // Unmatched addresses come back as index zero, so they land on the first bank
    addr_decode #(
        .NR_RULES (NR_OUTPUTS),
        .NR_IDX   (NR_OUTPUTS)
    ) i_addr_decode (
        .addr_i      (master_req_i.add),
        .addr_map_i  (addr_map_i),
        .idx_o       (port_sel),
        .dec_valid_o ()
    );

    // --------------------------------------------------
    // State and active bank registers
    // --------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            active_q <= '0;
        end else begin
            state_q  <= state_d;
            active_q <= active_d;
        end
    end

    // --------------------------------------------------
    // Transaction FSM
    // --------------------------------------------------

    always_comb begin
        master_rsp_o = '0;
        fwd_req      = 1'b0;
        state_d      = state_q;
        active_d     = active_q;

        unique case (state_q)
            IDLE: begin
                // Hand the request to the decoded bank and pass its grant back
                if (master_req_i.req) begin
                    fwd_req          = 1'b1;
                    master_rsp_o.gnt = bank_rsp_i[port_sel].gnt;
                    active_d         = port_sel;
                    // Without a grant the master keeps holding, so stay here
                    if (bank_rsp_i[port_sel].gnt) begin
                        state_d = PENDING;
                    end
                end
            end

            PENDING: begin
                // The response comes from the bank that granted last
                master_rsp_o.r_valid = bank_rsp_i[active_q].r_valid;
                master_rsp_o.r_rdata = bank_rsp_i[active_q].r_rdata;
                master_rsp_o.r_opc   = bank_rsp_i[active_q].r_opc;

                if (bank_rsp_i[active_q].r_valid) begin
                    // A new request may go out together with the response
                    if (master_req_i.req) begin
                        fwd_req          = 1'b1;
                        master_rsp_o.gnt = bank_rsp_i[port_sel].gnt;
                        active_d         = port_sel;
                        // A stalled bank is waited on from IDLE
                        state_d = bank_rsp_i[port_sel].gnt ? PENDING : IDLE;
                    end else begin
                        state_d = IDLE;
                    end
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // --------------------------------------------------
    // Request fan-out
    // --------------------------------------------------

    // Address, wen, wdata and be go to every bank
    // Only req is raised at the selected bank
    always_comb begin
        for (int unsigned i = 0; i < NR_OUTPUTS; i++) begin
            bank_req_o[i]     = master_req_i;
            bank_req_o[i].req = fwd_req && (port_sel == SEL_WIDTH'(i));
        end
    end

endmodule

`default_nettype wire

/* src/tcdm_sram_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_settings.svh"

// Single-port SRAM bank with a TCDM slave port
module tcdm_sram_bank #(
    parameter int unsigned WAIT_STATES = 0
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  tcdm_pkg::tcdm_req_t req_i,
    output tcdm_pkg::tcdm_rsp_t rsp_o
);

    localparam int unsigned CNT_WIDTH  = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam int unsigned OFFS_MSB   = $clog2(`TCDM_BANK_REGION) - 1;
    localparam int unsigned WORD_WIDTH = $clog2(`TCDM_BANK_DEPTH);

    logic [`TCDM_DATA_WIDTH-1:0] mem_q [`TCDM_BANK_DEPTH];
    logic [CNT_WIDTH-1:0]        wait_cnt_q;
    logic [OFFS_MSB-2:0]         offset;
    logic                        in_range;
    logic                        gnt;
    logic                        valid_q;
    logic                        opc_q;
    logic [`TCDM_DATA_WIDTH-1:0] rdata_q;

    // The word offset is taken from inside the bank region
    // Anything past the depth is an error
    assign offset   = req_i.add[OFFS_MSB:2];
    assign in_range = (offset < `TCDM_BANK_DEPTH);

    // Grant once the request has been held for the configured number of cycles
    assign gnt = req_i.req && (wait_cnt_q == CNT_WIDTH'(WAIT_STATES));

    // --------------------------------------------------
    // Control registers
    // --------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wait_cnt_q <= '0;
            valid_q    <= 1'b0;
            opc_q      <= 1'b0;
        end else begin
            // Count stalled cycles, restart after every grant or idle cycle
            wait_cnt_q <= (req_i.req && !gnt) ? wait_cnt_q + 1'b1 : '0;
            valid_q    <= gnt;
            if (gnt) begin
                opc_q <= !in_range;
            end
        end
    end

    // --------------------------------------------------
    // Storage and read data
    // --------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (gnt) begin
            // Reads outside the bank and all writes return zero
            rdata_q <= (req_i.wen && in_range) ? mem_q[offset[WORD_WIDTH-1:0]] : '0;
            if (!req_i.wen && in_range) begin
                for (int unsigned b = 0; b < `TCDM_BE_WIDTH; b++) begin
                    if (req_i.be[b]) begin
                        mem_q[offset[WORD_WIDTH-1:0]][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        rsp_o.gnt     = gnt;
        rsp_o.r_valid = valid_q;
        rsp_o.r_rdata = rdata_q;
        rsp_o.r_opc   = opc_q;
    end

endmodule

`default_nettype wire

/* src/tcdm_subsystem_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_settings.svh"

// TCDM subsystem with one core port and three SRAM banks
module tcdm_subsystem_top (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  tcdm_pkg::tcdm_req_t core_req_i,
    output tcdm_pkg::tcdm_rsp_t core_rsp_o
);

    localparam int unsigned IDX_WIDTH = $clog2(`TCDM_NR_BANKS);

    tcdm_pkg::addr_map_rule_t addr_map [`TCDM_NR_BANKS];
    tcdm_pkg::tcdm_req_t      bank_req [`TCDM_NR_BANKS];
    tcdm_pkg::tcdm_rsp_t      bank_rsp [`TCDM_NR_BANKS];

    // --------------------------------------------------
    // Address map and banks
    // --------------------------------------------------

    for (genvar i = 0; i < `TCDM_NR_BANKS; i++) begin : gen_bank
        // Bank i owns one contiguous region above the map base
        assign addr_map[i] = '{
            idx:        IDX_WIDTH'(i),
            start_addr: `TCDM_MAP_BASE + 32'(i) * `TCDM_BANK_REGION,
            end_addr:   `TCDM_MAP_BASE + 32'(i + 1) * `TCDM_BANK_REGION
        };

        // Only the last bank stalls its grant
        tcdm_sram_bank #(
            .WAIT_STATES ((i == 2) ? `TCDM_BANK2_WAIT : 0)
        ) i_bank (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .req_i  (bank_req[i]),
            .rsp_o  (bank_rsp[i])
        );
    end

    tcdm_demux #(
        .NR_OUTPUTS (`TCDM_NR_BANKS)
    ) i_tcdm_demux (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .addr_map_i   (addr_map),
        .master_req_i (core_req_i),
        .master_rsp_o (core_rsp_o),
        .bank_req_o   (bank_req),
        .bank_rsp_i   (bank_rsp)
    );

endmodule

`default_nettype wire

/* verif/tcdm_subsystem_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

// Protocol checks on the core-side TCDM port of the subsystem
module tcdm_subsystem_assertions (
    input logic                clk_i,
    input logic                rst_ni,
    input tcdm_pkg::tcdm_req_t core_req_i,
    input tcdm_pkg::tcdm_rsp_t core_rsp_o
);

    // High while a granted request still waits for its response
    logic pending_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (core_rsp_o.gnt) begin
            pending_q <= 1'b1;
        end else if (core_rsp_o.r_valid) begin
            pending_q <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Port properties
    // --------------------------------------------------

    // Without a fresh grant alongside it, a response is not repeated in the next cycle
    rvalid_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_o.r_valid && !core_rsp_o.gnt |=> !core_rsp_o.r_valid)
        else $error("r_valid held for more than one cycle");

    // Every response needs an earlier grant
    rvalid_after_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_o.r_valid |-> pending_q)
        else $error("r_valid without an outstanding grant");

    // A stalled request keeps all of its fields
    req_stable_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_req_i.req && !core_rsp_o.gnt |=> $stable(core_req_i))
        else $error("request changed while waiting for gnt");

    gnt_low_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !core_rsp_o.gnt)
        else $error("gnt raised during reset");

endmodule

bind tcdm_subsystem_top tcdm_subsystem_assertions i_tcdm_subsystem_assertions (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .core_req_i (core_req_i),
    .core_rsp_o (core_rsp_o)
);

`default_nettype wire

/* verif/tb_tcdm_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "tcdm_settings.svh"

module tb_tcdm_subsystem;

    localparam int TIMEOUT = 50;

    logic                        clk_i;
    logic                        rst_ni;
    tcdm_pkg::tcdm_req_t         core_req_i;
    tcdm_pkg::tcdm_rsp_t         core_rsp_o;
    int                          seed = 69;
    int                          err_count = 0;
    int                          tests_passed = 0;
    int                          tests_failed = 0;
    bit                          timed_out = 1'b0;
    // Expected memory contents, keyed by bank and word offset
    logic [`TCDM_DATA_WIDTH-1:0] shadow [int];

    tcdm_subsystem_top i_tcdm_subsystem_top (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .core_req_i (core_req_i),
        .core_rsp_o (core_rsp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Address map model
    // --------------------------------------------------

    function automatic logic [31:0] bank_addr(input int bank, input logic [31:0] offs);
        return `TCDM_MAP_BASE + bank * `TCDM_BANK_REGION + offs;
    endfunction

    // Unmapped addresses land in bank 0
    // The word offset is taken from bits 11:2
    function automatic int word_key(input logic [31:0] addr);
        int bank;
        bank = 0;
        if (addr >= `TCDM_MAP_BASE && addr < `TCDM_MAP_BASE + `TCDM_NR_BANKS * `TCDM_BANK_REGION)
            bank = (addr - `TCDM_MAP_BASE) / `TCDM_BANK_REGION;
        return bank * 1024 + int'(addr[11:2]);
    endfunction

    function automatic bit in_range(input logic [31:0] addr);
        return int'(addr[11:2]) < `TCDM_BANK_DEPTH;
    endfunction

    function automatic tcdm_pkg::tcdm_rsp_t exp_rsp(input logic [31:0] data, input logic opc);
        return '{gnt: 1'b0, r_valid: 1'b1, r_rdata: data, r_opc: opc};
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------

    task automatic compare_rsp(input tcdm_pkg::tcdm_rsp_t got, input tcdm_pkg::tcdm_rsp_t exp,
                               input bit check_data, input string msg);
        if (got.r_opc !== exp.r_opc || (check_data && got.r_rdata !== exp.r_rdata)) begin
            $display("MISMATCH at %0t: %s, got data %h opc %b, expected data %h opc %b",
                     $time, msg, got.r_rdata, got.r_opc, exp.r_rdata, exp.r_opc);
            err_count++;
        end
    endtask

    task automatic compare_latency(input int got, input int exp, input string msg);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s, got %0d cycles, expected %0d", $time, msg, got, exp);
            err_count++;
        end
    endtask

    // --------------------------------------------------
    // Bus driver
    // --------------------------------------------------

    // Outputs are sampled at the falling edge, where they have settled
    task automatic wait_grant(output int cycles);
        cycles = 0;
        if (timed_out) return;
        @(negedge clk_i);
        while (!core_rsp_o.gnt && cycles < TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!core_rsp_o.gnt) begin
            $display("Timeout at %0t: no grant after %0d cycles", $time, TIMEOUT);
            timed_out = 1'b1;
            err_count++;
        end
    endtask

    task automatic wait_response(output tcdm_pkg::tcdm_rsp_t rsp, output int cycles);
        cycles = 0;
        rsp    = '0;
        if (timed_out) return;
        @(negedge clk_i);
        cycles = 1;
        while (!core_rsp_o.r_valid && cycles < TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        rsp = core_rsp_o;
        if (!core_rsp_o.r_valid) begin
            $display("Timeout at %0t: no response after %0d cycles", $time, TIMEOUT);
            timed_out = 1'b1;
            err_count++;
        end
    endtask

    task automatic drive_req(input logic wen, input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be);
        @(posedge clk_i);
        core_req_i <= '{req: 1'b1, add: addr, wen: wen, wdata: wdata, be: be};
    endtask

    // Request held until the grant, dropped at the accepting edge
    task automatic bus_access(input logic wen, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be, output tcdm_pkg::tcdm_rsp_t rsp,
                              output int gnt_lat, output int rsp_lat);
        drive_req(wen, addr, wdata, be);
        wait_grant(gnt_lat);
        @(posedge clk_i);
        core_req_i <= '0;
        wait_response(rsp, rsp_lat);
    endtask

    task automatic tcdm_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be, output tcdm_pkg::tcdm_rsp_t rsp);
        int                          gnt_lat;
        int                          rsp_lat;
        logic [`TCDM_DATA_WIDTH-1:0] word;
        bus_access(1'b0, addr, wdata, be, rsp, gnt_lat, rsp_lat);
        word = shadow.exists(word_key(addr)) ? shadow[word_key(addr)] : '0;
        for (int b = 0; b < `TCDM_BE_WIDTH; b++)
            if (be[b]) word[8*b +: 8] = wdata[8*b +: 8];
        if (in_range(addr)) shadow[word_key(addr)] = word;
    endtask

    task automatic tcdm_read(input logic [31:0] addr, output tcdm_pkg::tcdm_rsp_t rsp,
                             output int gnt_lat, output int rsp_lat);
        bus_access(1'b1, addr, '0, '1, rsp, gnt_lat, rsp_lat);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: FAILED with %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    // Every bank uses the same offset so a crossed route shows up as wrong data
    task automatic route_to_each_bank();
        int                  errs;
        int                  gl;
        int                  rl;
        tcdm_pkg::tcdm_rsp_t rsp;
        errs = err_count;
        for (int b = 0; b < `TCDM_NR_BANKS; b++) begin
            tcdm_write(bank_addr(b, 32'h10), $random(seed), 4'hf, rsp);
            compare_rsp(rsp, exp_rsp('0, 1'b0), 1'b0, $sformatf("routing write bank %0d", b));
        end
        for (int b = 0; b < `TCDM_NR_BANKS; b++) begin
            tcdm_read(bank_addr(b, 32'h10), rsp, gl, rl);
            compare_rsp(rsp, exp_rsp(shadow[word_key(bank_addr(b, 32'h10))], 1'b0), 1'b1,
                        $sformatf("routing read bank %0d", b));
        end
        finish_test("routing", errs);
    endtask

    task automatic route_unmapped_address();
        int                  errs;
        int                  gl;
        int                  rl;
        tcdm_pkg::tcdm_rsp_t rsp;
        errs = err_count;
        tcdm_write(32'h0000_5004, $random(seed), 4'hf, rsp);
        tcdm_read(32'h0000_0004, rsp, gl, rl);
        compare_rsp(rsp, exp_rsp(shadow[word_key(32'h0000_0004)], 1'b0), 1'b1,
                    "unmapped write read back from bank 0");
        finish_test("default_route", errs);
    endtask

    task automatic merge_byte_enables();
        int                  errs;
        int                  gl;
        int                  rl;
        tcdm_pkg::tcdm_rsp_t rsp;
        errs = err_count;
        tcdm_write(bank_addr(1, 32'h20), 32'h1122_3344, 4'b1111, rsp);
        tcdm_write(bank_addr(1, 32'h20), 32'haabb_ccdd, 4'b0101, rsp);
        tcdm_read(bank_addr(1, 32'h20), rsp, gl, rl);
        compare_rsp(rsp, exp_rsp(shadow[word_key(bank_addr(1, 32'h20))], 1'b0), 1'b1,
                    "merged bytes");
        finish_test("byte_enables", errs);
    endtask

    task automatic reject_out_of_range();
        int                  errs;
        int                  gl;
        int                  rl;
        tcdm_pkg::tcdm_rsp_t rsp;
        errs = err_count;
        tcdm_write(bank_addr(1, 32'h0), $random(seed), 4'hf, rsp);
        tcdm_read(bank_addr(1, 32'h800), rsp, gl, rl);
        compare_rsp(rsp, exp_rsp('0, 1'b1), 1'b1, "read beyond bank depth");
        tcdm_write(bank_addr(1, 32'h800), $random(seed), 4'hf, rsp);
        compare_rsp(rsp, exp_rsp('0, 1'b1), 1'b1, "write beyond bank depth");
        tcdm_read(bank_addr(1, 32'h0), rsp, gl, rl);
        compare_rsp(rsp, exp_rsp(shadow[word_key(bank_addr(1, 32'h0))], 1'b0), 1'b1,
                    "bank 1 word 0 after rejected write");
        finish_test("out_of_range", errs);
    endtask

    task automatic measure_latency();
        int                  errs;
        int                  gl;
        int                  rl;
        tcdm_pkg::tcdm_rsp_t rsp;
        errs = err_count;
        for (int b = 0; b < `TCDM_NR_BANKS; b++) begin
            tcdm_read(bank_addr(b, 32'h10), rsp, gl, rl);
            compare_latency(gl, (b == 2) ? `TCDM_BANK2_WAIT : 0,
                            $sformatf("req to gnt, bank %0d", b));
            compare_latency(rl, 1, $sformatf("gnt to r_valid, bank %0d", b));
        end
        finish_test("latency", errs);
    endtask

    // The bank 2 request goes out at the edge that accepts the bank 0 read
    task automatic issue_back_to_back();
        int                  errs;
        int                  gl;
        int                  rl;
        tcdm_pkg::tcdm_rsp_t rsp0;
        tcdm_pkg::tcdm_rsp_t rsp2;
        errs = err_count;
        drive_req(1'b1, bank_addr(0, 32'h10), '0, '1);
        wait_grant(gl);
        @(posedge clk_i);
        core_req_i <= '{req: 1'b1, add: bank_addr(2, 32'h10), wen: 1'b1, wdata: '0, be: '1};
        wait_response(rsp0, rl);
        compare_latency(rl, 1, "bank 0 response under a new request");
        compare_rsp(rsp0, exp_rsp(shadow[word_key(bank_addr(0, 32'h10))], 1'b0), 1'b1,
                    "first response from bank 0");
        wait_grant(gl);
        // The bank 2 wait already runs in the cycle of the bank 0 response
        compare_latency(gl, `TCDM_BANK2_WAIT - 1, "bank 2 grant after the overlapping response");
        @(posedge clk_i);
        core_req_i <= '0;
        wait_response(rsp2, rl);
        compare_rsp(rsp2, exp_rsp(shadow[word_key(bank_addr(2, 32'h10))], 1'b0), 1'b1,
                    "second response from bank 2");
        finish_test("back_to_back", errs);
    endtask

    initial begin
        core_req_i = '0;
        rst_ni     = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        route_to_each_bank();
        route_unmapped_address();
        merge_byte_enables();
        reject_out_of_range();
        measure_latency();
        issue_back_to_back();
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/tcdm_pkg.sv
src/addr_decode.sv
tcdm_demux/tcdm_demux.sv
src/tcdm_sram_bank.sv
src/tcdm_subsystem_top.sv
verif/tcdm_subsystem_assertions.sv
verif/tb_tcdm_subsystem.sv
